/* vlog.f */
hdl/cpu_pkg.sv
hdl/csr_file.sv
hdl/excp_ctrl.sv
hdl/tlb_array.sv
hdl/csr_unit.sv
tests/csr_unit_assertions.sv
tests/tb_csr_unit.sv

/* tests/tb_csr_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit
    import cpu_pkg::*;
;

    logic      clk;
    logic      rst_n;
    csr_addr_t csr_addr;
    logic      csr_we;
    logic      csr_masked;
    u32_t      csr_wr_data;
    u32_t      csr_wr_mask;
    u32_t      csr_rd_data;
    excp_req_t excp_req;
    tlb_op_t   tlb_op;
    redirect_t redirect;

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          test_base;

    // Model of the register views, one slot per CSR number
    u32_t      m [18];
    csr_addr_t addr_tab [18];
    u32_t      wm_tab [18];
    string     name_tab [18];

    // Model of the TLB entries
    logic        ent_exist [8];
    logic [18:0] ent_vppn [8];
    logic [5:0]  ent_ps [8];
    logic        ent_g [8];
    logic [9:0]  ent_asid [8];
    u32_t        ent_elo0 [8];
    u32_t        ent_elo1 [8];

    // Stimulus scratch
    excp_req_t r_req;
    tlb_op_t   r_op;
    u32_t      r_pc;
    csr_addr_t r_addr;

    csr_unit #(
        .TLB_ENTRIES(8)
    ) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_addr    (csr_addr),
        .csr_we      (csr_we),
        .csr_masked  (csr_masked),
        .csr_wr_data (csr_wr_data),
        .csr_wr_mask (csr_wr_mask),
        .csr_rd_data (csr_rd_data),
        .excp_req    (excp_req),
        .tlb_op      (tlb_op),
        .redirect    (redirect)
    );

    bind csr_unit csr_unit_assertions u_assertions (
        .clk            (clk),
        .rst_n          (rst_n),
        .excp_valid     (excp_req.valid),
        .redirect_valid (redirect.valid),
        .tlb_op         (tlb_op)
    );

    always #10 clk = ~clk;

    // Taps 32, 22, 2, 1; one step per bit taken
    function automatic logic [31:0] rnd(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int slot_of(input csr_addr_t a);
        for (int s = 0; s < 18; s++) begin
            if (addr_tab[s] == a) begin
                return s;
            end
        end
        return -1;
    endfunction

    function automatic u32_t model_read(input csr_addr_t a);
        int s;
        s = slot_of(a);
        if (s < 0) begin
            return '0;
        end
        // pgd picks its half by badv bit 31
        if (s == 13) begin
            return m[4][31] ? m[12] : m[11];
        end
        return m[s];
    endfunction

    task automatic model_write(input csr_addr_t a, input u32_t data, input u32_t mask,
                               input logic masked);
        int   s;
        u32_t old;
        u32_t merged;
        s = slot_of(a);
        if (s >= 0 && s != 13) begin
            old    = model_read(a);
            merged = masked ? ((old & ~mask) | (data & mask)) : data;
            m[s]   = (old & ~wm_tab[s]) | (merged & wm_tab[s]);
        end
    endtask

    task automatic model_reset();
        for (int s = 0; s < 18; s++) begin
            for (int b = 0; b < 32; b++) begin
                m[s][b] = wm_tab[s][b] ? 1'bx : 1'b0;
            end
        end
        // da set, datf and datm strongly-ordered uncached
        m[0]         = 32'h0000_00a8;
        m[2][1:0]    = 2'b00;
        m[2][30:16]  = 'x;
        m[10][23:16] = 8'd10;
        m[13]        = '0;
        for (int i = 0; i < 8; i++) begin
            ent_exist[i] = 1'b0;
        end
    endtask

    task automatic model_exception(input excp_req_t req);
        m[1][1:0]   = m[0][1:0];
        m[1][2]     = m[0][2];
        m[0][2:0]   = 3'b000;
        m[2][21:16] = req.ecode;
        m[2][30:22] = req.esubcode;
        m[3]        = req.pc;
        m[4]        = req.badv;
    endtask

    task automatic model_ertn();
        m[0][1:0] = m[1][1:0];
        m[0][2]   = m[1][2];
    endtask

    task automatic model_search();
        logic       hit;
        logic [2:0] idx;
        hit = 1'b0;
        idx = '0;
        for (int i = 7; i >= 0; i--) begin
            if (ent_exist[i] && ent_vppn[i] == m[7][31:13] &&
                (ent_g[i] || ent_asid[i] == m[10][9:0])) begin
                hit = 1'b1;
                idx = i[2:0];
            end
        end
        m[6][31] = ~hit;
        if (hit) begin
            m[6][2:0] = idx;
        end
    endtask

    task automatic model_tlb_read();
        int i;
        i = m[6][2:0];
        m[6][31] = ~ent_exist[i];
        if (ent_exist[i]) begin
            m[6][29:24] = ent_ps[i];
            m[7]        = {ent_vppn[i], 13'd0};
            m[8]        = ent_elo0[i];
            m[9]        = ent_elo1[i];
            m[10][9:0]  = ent_asid[i];
        end else begin
            m[6][29:24] = '0;
            m[7]        = '0;
            m[8]        = '0;
            m[9]        = '0;
            m[10][9:0]  = '0;
        end
    endtask

    task automatic model_tlb_write();
        int i;
        i = m[6][2:0];
        ent_exist[i] = ~m[6][31];
        ent_vppn[i]  = m[7][31:13];
        ent_ps[i]    = m[6][29:24];
        ent_g[i]     = m[8][6] & m[9][6];
        ent_asid[i]  = m[10][9:0];
        ent_elo0[i]  = m[8];
        ent_elo1[i]  = m[9];
    endtask

    task automatic check(input string name, input u32_t got, input u32_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    // Combinational read on a quiet cycle, only the bits in care compared
    task automatic check_bits(input csr_addr_t a, input string name, input u32_t care,
                              input u32_t exp);
        @(negedge clk);
        csr_addr = a;
        csr_we   = 1'b0;
        #1;
        check(name, csr_rd_data & care, exp);
    endtask

    task automatic check_reg(input csr_addr_t a);
        int s;
        s = slot_of(a);
        check_bits(a, s < 0 ? "csr_rd_data(unknown)" : name_tab[s], '1, model_read(a));
    endtask

    task automatic csr_write(input csr_addr_t a, input u32_t data, input u32_t mask,
                             input logic masked);
        model_write(a, data, mask, masked);
        @(negedge clk);
        csr_addr    = a;
        csr_we      = 1'b1;
        csr_masked  = masked;
        csr_wr_data = data;
        csr_wr_mask = mask;
        @(negedge clk);
        csr_we = 1'b0;
    endtask

    // One-cycle strobe of any mix of inputs, waits for the redirect if any
    task automatic fire(input excp_req_t req, input tlb_op_t op, input logic we,
                        input csr_addr_t a, input u32_t data, input u32_t exp_pc);
        int n;
        n = 0;
        @(negedge clk);
        excp_req    = req;
        tlb_op      = op;
        csr_we      = we;
        csr_addr    = a;
        csr_wr_data = data;
        csr_masked  = 1'b0;
        if (req.valid) begin
            do begin
                @(posedge clk);
                #1;
                n++;
            end while (!redirect.valid && n < 4);
            if (!redirect.valid) begin
                errors++;
                $display("redirect did not arrive within 4 cycles of the strobe");
            end else begin
                check("redirect latency", n, 1);
                check("redirect.pc", redirect.pc, exp_pc);
            end
        end
        @(negedge clk);
        excp_req = '0;
        tlb_op   = '0;
        csr_we   = 1'b0;
    endtask

    task automatic end_test(input string name);
        $display("test %s done, %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    task automatic random_exception(input logic ertn);
        r_req          = '0;
        r_req.valid    = 1'b1;
        r_req.ertn     = ertn;
        r_req.ecode    = rnd(6);
        r_req.esubcode = rnd(9);
        r_req.pc       = rnd(32);
        r_req.badv     = rnd(32);
    endtask

    initial begin
        #2_000_000;
        $display("simulation time limit reached, run stopped");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        csr_addr    = '0;
        csr_we      = 1'b0;
        csr_masked  = 1'b0;
        csr_wr_data = '0;
        csr_wr_mask = '0;
        excp_req    = '0;
        tlb_op      = '0;
        lfsr        = 32'h7b5e;
        errors      = 0;
        checks      = 0;
        test_base   = 0;
        addr_tab = '{CSR_CRMD, CSR_PRMD, CSR_ESTAT, CSR_ERA, CSR_BADV, CSR_EENTRY,
                     CSR_TLBIDX, CSR_TLBEHI, CSR_TLBELO0, CSR_TLBELO1, CSR_ASID,
                     CSR_PGDL, CSR_PGDH, CSR_PGD, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2,
                     CSR_SAVE3};
        // tlbidx index is 3 bits wide with 8 entries
        wm_tab = '{WM_CRMD, WM_PRMD, WM_ESTAT, '1, '1, WM_EENTRY, WM_TLBIDX | 32'h7,
                   WM_TLBEHI, WM_TLBELO, WM_TLBELO, WM_ASID, WM_PGD, WM_PGD, '0,
                   '1, '1, '1, '1};
        name_tab = '{"crmd", "prmd", "estat", "era", "badv", "eentry", "tlbidx",
                     "tlbehi", "tlbelo0", "tlbelo1", "asid", "pgdl", "pgdh", "pgd",
                     "save0", "save1", "save2", "save3"};
        model_reset();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_reg(CSR_CRMD);
        // Interrupt status clear, ASID width 10 in bits 23:16
        check_bits(CSR_ESTAT, "estat.is", 32'h0000_1fff, 32'h0000_0000);
        check_bits(CSR_ASID, "asid.asidbits", 32'h00ff_0000, 32'h000a_0000);
        end_test("reset");

        // Define every register first, then mix plain and masked writes
        for (int s = 0; s < 18; s++) begin
            csr_write(addr_tab[s], rnd(32), '0, 1'b0);
        end
        // Cause fields of estat only change through a trap
        random_exception(1'b0);
        r_pc = m[5];
        model_exception(r_req);
        fire(r_req, '0, 1'b0, CSR_SAVE0, '0, r_pc);
        for (int k = 0; k < 80; k++) begin
            if (rnd(4) == 0) begin
                r_addr = 14'h200 | 14'(rnd(8));
            end else begin
                r_addr = addr_tab[rnd(5) % 18];
            end
            csr_write(r_addr, rnd(32), rnd(32), rnd(1));
            check_reg(r_addr);
            check_reg(CSR_PGD);
        end
        for (int s = 0; s < 18; s++) begin
            check_reg(addr_tab[s]);
        end
        end_test("csr_write");

        for (int k = 0; k < 20; k++) begin
            csr_write(CSR_CRMD, rnd(32), '0, 1'b0);
            csr_write(CSR_EENTRY, rnd(32), '0, 1'b0);
            random_exception(1'b0);
            r_pc = m[5];
            model_exception(r_req);
            fire(r_req, '0, 1'b0, CSR_SAVE0, '0, r_pc);
            for (int s = 0; s < 5; s++) begin
                check_reg(addr_tab[s]);
            end
        end
        end_test("exception");

        for (int k = 0; k < 20; k++) begin
            csr_write(CSR_PRMD, rnd(32), '0, 1'b0);
            csr_write(CSR_ERA, rnd(32), '0, 1'b0);
            random_exception(1'b1);
            r_pc = m[3];
            model_ertn();
            fire(r_req, '0, 1'b0, CSR_SAVE0, '0, r_pc);
            check_reg(CSR_CRMD);
            check_reg(CSR_PRMD);
            check_reg(CSR_ERA);
        end
        end_test("ertn");

        // Small vppn and asid pools so searches collide
        for (int k = 0; k < 16; k++) begin
            csr_write(CSR_TLBIDX, {(rnd(3) == 0), 1'b0, 6'(rnd(6)), 21'd0, 3'(rnd(3))},
                      '0, 1'b0);
            csr_write(CSR_TLBEHI, {17'h0a5c3, 2'(rnd(2)), 13'd0}, '0, 1'b0);
            csr_write(CSR_TLBELO0, rnd(32), '0, 1'b0);
            csr_write(CSR_TLBELO1, rnd(32), '0, 1'b0);
            csr_write(CSR_ASID, {22'd0, 9'h1e0, 1'(rnd(1))}, '0, 1'b0);
            model_tlb_write();
            r_op    = '0;
            r_op.wr = 1'b1;
            fire('0, r_op, 1'b0, CSR_SAVE0, '0, '0);
        end
        for (int k = 0; k < 16; k++) begin
            csr_write(CSR_TLBEHI, {17'h0a5c3, 2'(rnd(2)), 13'd0}, '0, 1'b0);
            csr_write(CSR_ASID, {22'd0, 9'h1e0, 1'(rnd(1))}, '0, 1'b0);
            model_search();
            r_op      = '0;
            r_op.srch = 1'b1;
            fire('0, r_op, 1'b0, CSR_SAVE0, '0, '0);
            check_reg(CSR_TLBIDX);
        end
        for (int i = 0; i < 8; i++) begin
            csr_write(CSR_TLBIDX, 32'(i), '0, 1'b0);
            model_tlb_read();
            r_op    = '0;
            r_op.rd = 1'b1;
            fire('0, r_op, 1'b0, CSR_SAVE0, '0, '0);
            for (int s = 6; s < 11; s++) begin
                check_reg(addr_tab[s]);
            end
        end
        end_test("tlb");

        // Exception beats search and instruction write
        random_exception(1'b0);
        r_pc = m[5];
        model_exception(r_req);
        r_op      = '0;
        r_op.srch = 1'b1;
        fire(r_req, r_op, 1'b1, CSR_SAVE0, rnd(32), r_pc);
        for (int s = 0; s < 7; s++) begin
            check_reg(addr_tab[s]);
        end
        check_reg(CSR_SAVE0);
        // Search beats instruction write
        model_search();
        fire('0, r_op, 1'b1, CSR_SAVE1, rnd(32), '0);
        check_reg(CSR_TLBIDX);
        check_reg(CSR_SAVE1);
        end_test("collision");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/csr_unit_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_unit_assertions (
    input wire logic       clk,
    input wire logic       rst_n,
    input wire logic       excp_valid,
    input wire logic       redirect_valid,
    input wire logic [2:0] tlb_op
);

    // Redirect only ever follows a strobe one clock earlier
    a_redirect_follows: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect_valid |-> $past(excp_valid)
    ) else $error("redirect without an exception or ertn strobe one cycle before");

    // Every strobe is answered on the next clock, so the pulse mirrors the strobe
    a_redirect_on_strobe: assert property (
        @(posedge clk) disable iff (!rst_n)
        excp_valid |=> redirect_valid
    ) else $error("exception or ertn strobe without a redirect one cycle later");

    // Quiet in reset and in the first cycle out of it
    a_redirect_reset: assert property (
        @(posedge clk)
        (!rst_n || $past(!rst_n)) |-> !redirect_valid
    ) else $error("redirect valid during or right after reset");

    a_tlb_op_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(tlb_op)
    ) else $error("more than one TLB operation in a cycle");

endmodule

`default_nettype wire

/* hdl/csr_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_unit
    import cpu_pkg::*;
#(
    parameter int TLB_ENTRIES = 8
) (
    input  wire logic      clk,
    input  wire logic      rst_n,
    // CSR instruction port
    input  wire csr_addr_t csr_addr,
    input  wire logic      csr_we,
    input  wire logic      csr_masked,
    input  wire u32_t      csr_wr_data,
    input  wire u32_t      csr_wr_mask,
    output u32_t           csr_rd_data,
    // Trap and return strobes
    input  wire excp_req_t excp_req,
    // TLB instruction strobes
    input  wire tlb_op_t   tlb_op,
    output redirect_t      redirect
);

    csr_t         csr;
    excp_wr_req_t excp_wr;
    tlb_wr_req_t  tlb_wr;

    // Register file, also arbitrates the three writers
    csr_file #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) u_csr_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr    (csr_addr),
        .we      (csr_we),
        .masked  (csr_masked),
        .wr_data (csr_wr_data),
        .wr_mask (csr_wr_mask),
        .rd_data (csr_rd_data),
        .excp_wr (excp_wr),
        .tlb_wr  (tlb_wr),
        .csr     (csr)
    );

    excp_ctrl u_excp_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (excp_req),
        .csr      (csr),
        .excp_wr  (excp_wr),
        .redirect (redirect)
    );

    tlb_array #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) u_tlb_array (
        .clk    (clk),
        .rst_n  (rst_n),
        .op     (tlb_op),
        .csr    (csr),
        .tlb_wr (tlb_wr)
    );

endmodule

`default_nettype wire

/* hdl/tlb_array.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_array
    import cpu_pkg::*;
#(
    parameter int TLB_ENTRIES = 8
) (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire tlb_op_t op,
    input  wire csr_t    csr,
    output tlb_wr_req_t  tlb_wr
);

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    typedef struct packed {
        logic [18:0] vppn;
        logic [5:0]  ps;
        logic        g;
        logic [9:0]  asid;
        tlbelo_t     elo0;
        tlbelo_t     elo1;
    } tlb_entry_t;

    // Existence bits need a reset, entry payload does not
    logic [TLB_ENTRIES-1:0] exist_q;
    tlb_entry_t             ent_q [TLB_ENTRIES];

    logic             hit;
    logic [IDX_W-1:0] hit_idx;
    logic [IDX_W-1:0] idx;
    tlb_entry_t       rd_ent;

    assign idx    = csr.tlbidx.index[IDX_W-1:0];
    assign rd_ent = ent_q[idx];

    // Search, walking down so the lowest match wins
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (exist_q[i] && ent_q[i].vppn == csr.tlbehi.vppn &&
                (ent_q[i].g || ent_q[i].asid == csr.asid.asid)) begin
                hit     = 1'b1;
                hit_idx = IDX_W'(i);
            end
        end
    end

    // CSR results for search and read
    always_comb begin
        tlb_wr.we      = op.srch | op.rd;
        tlb_wr.tlbidx  = csr.tlbidx;
        tlb_wr.tlbehi  = csr.tlbehi;
        tlb_wr.tlbelo0 = csr.tlbelo0;
        tlb_wr.tlbelo1 = csr.tlbelo1;
        tlb_wr.asid    = csr.asid;
        if (op.srch) begin
            // Miss keeps the old index
            tlb_wr.tlbidx.ne = ~hit;
            if (hit) begin
                tlb_wr.tlbidx.index = 16'(hit_idx);
            end
        end else if (op.rd) begin
            tlb_wr.tlbidx.ne = ~exist_q[idx];
            if (exist_q[idx]) begin
                tlb_wr.tlbidx.ps    = rd_ent.ps;
                tlb_wr.tlbehi.vppn  = rd_ent.vppn;
                tlb_wr.tlbelo0      = rd_ent.elo0;
                tlb_wr.tlbelo1      = rd_ent.elo1;
                tlb_wr.asid.asid    = rd_ent.asid;
            end else begin
                tlb_wr.tlbidx.ps    = '0;
                tlb_wr.tlbehi.vppn  = '0;
                tlb_wr.tlbelo0      = '0;
                tlb_wr.tlbelo1      = '0;
                tlb_wr.asid.asid    = '0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exist_q <= '0;
        end else if (op.wr) begin
            exist_q[idx] <= ~csr.tlbidx.ne;
        end
    end

    // Global only when both halves say so
    always_ff @(posedge clk) begin
        if (op.wr) begin
            ent_q[idx].vppn <= csr.tlbehi.vppn;
            ent_q[idx].ps   <= csr.tlbidx.ps;
            ent_q[idx].g    <= csr.tlbelo0.g & csr.tlbelo1.g;
            ent_q[idx].asid <= csr.asid.asid;
            ent_q[idx].elo0 <= csr.tlbelo0;
            ent_q[idx].elo1 <= csr.tlbelo1;
        end
    end

endmodule

`default_nettype wire

/* hdl/excp_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module excp_ctrl
    import cpu_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire excp_req_t req,
    input  wire csr_t      csr,
    output excp_wr_req_t   excp_wr,
    output redirect_t      redirect
);

    logic redir_valid_q;
    u32_t redir_pc_q;

    // CSR update, same cycle as the strobe
    always_comb begin
        // Start from the current values so untouched fields hold
        excp_wr.we    = req.valid;
        excp_wr.crmd  = csr.crmd;
        excp_wr.prmd  = csr.prmd;
        excp_wr.estat = csr.estat;
        excp_wr.era   = csr.era;
        excp_wr.badv  = csr.badv;
        if (req.ertn) begin
            // Return: previous mode back into crmd
            excp_wr.crmd.plv = csr.prmd.pplv;
            excp_wr.crmd.ie  = csr.prmd.pie;
        end else begin
            // Trap: stash mode, enter kernel with interrupts off
            excp_wr.prmd.pplv     = csr.crmd.plv;
            excp_wr.prmd.pie      = csr.crmd.ie;
            excp_wr.crmd.plv      = 2'd0;
            excp_wr.crmd.ie       = 1'b0;
            excp_wr.estat.ecode   = req.ecode;
            excp_wr.estat.esubcode = req.esubcode;
            excp_wr.era           = req.pc;
            excp_wr.badv          = req.badv;
        end
    end

    // One-cycle valid pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redir_valid_q <= 1'b0;
        end else begin
            redir_valid_q <= req.valid;
        end
    end

    // Target sampled at the strobe, before the CSR write lands
    always_ff @(posedge clk) begin
        if (req.valid) begin
            redir_pc_q <= req.ertn ? csr.era : csr.eentry;
        end
    end

    assign redirect.valid = redir_valid_q;
    assign redirect.pc    = redir_pc_q;

endmodule

`default_nettype wire

/* hdl/csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_file
    import cpu_pkg::*;
#(
    parameter int TLB_ENTRIES = 8
) (
    input  wire logic         clk,
    input  wire logic         rst_n,
    // Instruction port
    input  wire csr_addr_t    addr,
    input  wire logic         we,
    input  wire logic         masked,
    input  wire u32_t         wr_data,
    input  wire u32_t         wr_mask,
    output u32_t              rd_data,
    // Exception and TLB update requests
    input  wire excp_wr_req_t excp_wr,
    input  wire tlb_wr_req_t  tlb_wr,
    output csr_t              csr
);

    localparam int   IDX_W    = $clog2(TLB_ENTRIES);
    localparam u32_t IDX_MASK = u32_t'((1 << IDX_W) - 1);

    // Raw storage, reserved bits are cleaned on the way out
    csr_t q;
    csr_t d;
    u32_t wr_merged;

    // Keep old bits outside the writable set
    function automatic u32_t legal(input u32_t old, input u32_t nv, input u32_t wm);
        return (old & ~wm) | (nv & wm);
    endfunction

    // Register image with reserved fields forced to zero
    always_comb begin
        csr = q;
        csr.crmd.r0         = '0;
        csr.prmd.r0         = '0;
        csr.estat.r0_hi     = '0;
        csr.estat.r0_lo     = '0;
        // Only the software interrupt bits exist here
        csr.estat.is[12:2]  = '0;
        csr.eentry[5:0]     = '0;
        csr.tlbidx.r0_hi    = '0;
        csr.tlbidx.r0_lo    = '0;
        csr.tlbidx.index    = q.tlbidx.index & IDX_MASK[15:0];
        csr.tlbehi.r0       = '0;
        csr.tlbelo0.r0_hi   = '0;
        csr.tlbelo0.r0_lo   = '0;
        csr.tlbelo1.r0_hi   = '0;
        csr.tlbelo1.r0_lo   = '0;
        csr.asid.r0_hi      = '0;
        csr.asid.r0_lo      = '0;
        csr.asid.asidbits   = 8'(ASID_WID);
        csr.pgdl[11:0]      = '0;
        csr.pgdh[11:0]      = '0;
        // Base picked by the upper half of the bad address
        csr.pgd = csr.badv[31] ? csr.pgdh : csr.pgdl;
    end

    // Read decode
    always_comb begin
        case (addr)
            CSR_CRMD:    rd_data = csr.crmd;
            CSR_PRMD:    rd_data = csr.prmd;
            CSR_ESTAT:   rd_data = csr.estat;
            CSR_ERA:     rd_data = csr.era;
            CSR_BADV:    rd_data = csr.badv;
            CSR_EENTRY:  rd_data = csr.eentry;
            CSR_TLBIDX:  rd_data = csr.tlbidx;
            CSR_TLBEHI:  rd_data = csr.tlbehi;
            CSR_TLBELO0: rd_data = csr.tlbelo0;
            CSR_TLBELO1: rd_data = csr.tlbelo1;
            CSR_ASID:    rd_data = csr.asid;
            CSR_PGDL:    rd_data = csr.pgdl;
            CSR_PGDH:    rd_data = csr.pgdh;
            CSR_PGD:     rd_data = csr.pgd;
            CSR_SAVE0:   rd_data = csr.save[0];
            CSR_SAVE1:   rd_data = csr.save[1];
            CSR_SAVE2:   rd_data = csr.save[2];
            CSR_SAVE3:   rd_data = csr.save[3];
            default:     rd_data = '0;
        endcase
    end

    // Exchange write: mask picks new data, old value elsewhere
    assign wr_merged = masked ? (rd_data & ~wr_mask) | (wr_data & wr_mask) : wr_data;

    // Next state, exception beats TLB beats instruction
    always_comb begin
        d = q;
        if (excp_wr.we) begin
            d.crmd.plv      = excp_wr.crmd.plv;
            d.crmd.ie       = excp_wr.crmd.ie;
            d.prmd.pplv     = excp_wr.prmd.pplv;
            d.prmd.pie      = excp_wr.prmd.pie;
            d.estat.ecode   = excp_wr.estat.ecode;
            d.estat.esubcode = excp_wr.estat.esubcode;
            d.era           = excp_wr.era;
            d.badv          = excp_wr.badv;
        end else if (tlb_wr.we) begin
            d.tlbidx  = tlb_wr.tlbidx;
            d.tlbehi  = tlb_wr.tlbehi;
            d.tlbelo0 = tlb_wr.tlbelo0;
            d.tlbelo1 = tlb_wr.tlbelo1;
            d.asid    = tlb_wr.asid;
        end else if (we) begin
            case (addr)
                CSR_CRMD:    d.crmd    = legal(rd_data, wr_merged, WM_CRMD);
                CSR_PRMD:    d.prmd    = legal(rd_data, wr_merged, WM_PRMD);
                CSR_ESTAT:   d.estat   = legal(rd_data, wr_merged, WM_ESTAT);
                CSR_ERA:     d.era     = wr_merged;
                CSR_BADV:    d.badv    = wr_merged;
                CSR_EENTRY:  d.eentry  = legal(rd_data, wr_merged, WM_EENTRY);
                CSR_TLBIDX:  d.tlbidx  = legal(rd_data, wr_merged, WM_TLBIDX | IDX_MASK);
                CSR_TLBEHI:  d.tlbehi  = legal(rd_data, wr_merged, WM_TLBEHI);
                CSR_TLBELO0: d.tlbelo0 = legal(rd_data, wr_merged, WM_TLBELO);
                CSR_TLBELO1: d.tlbelo1 = legal(rd_data, wr_merged, WM_TLBELO);
                CSR_ASID:    d.asid    = legal(rd_data, wr_merged, WM_ASID);
                CSR_PGDL:    d.pgdl    = legal(rd_data, wr_merged, WM_PGD);
                CSR_PGDH:    d.pgdh    = legal(rd_data, wr_merged, WM_PGD);
                CSR_SAVE0:   d.save[0] = wr_merged;
                CSR_SAVE1:   d.save[1] = wr_merged;
                CSR_SAVE2:   d.save[2] = wr_merged;
                CSR_SAVE3:   d.save[3] = wr_merged;
                // pgd and unknown numbers ignore writes
                default:     d = q;
            endcase
        end
    end

    // Mode and interrupt status come up known, the rest is left to software
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q.crmd     <= CRMD_RESET;
            q.estat.is <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

/* hdl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] u32_t;
    typedef logic [13:0] csr_addr_t;

    // Implemented ASID width, reported through asid.asidbits
    localparam int ASID_WID = 10;

    // CSR numbers
    localparam csr_addr_t CSR_CRMD    = 14'h000;
    localparam csr_addr_t CSR_PRMD    = 14'h001;
    localparam csr_addr_t CSR_ESTAT   = 14'h005;
    localparam csr_addr_t CSR_ERA     = 14'h006;
    localparam csr_addr_t CSR_BADV    = 14'h007;
    localparam csr_addr_t CSR_EENTRY  = 14'h00c;
    localparam csr_addr_t CSR_TLBIDX  = 14'h010;
    localparam csr_addr_t CSR_TLBEHI  = 14'h011;
    localparam csr_addr_t CSR_TLBELO0 = 14'h012;
    localparam csr_addr_t CSR_TLBELO1 = 14'h013;
    localparam csr_addr_t CSR_ASID    = 14'h018;
    localparam csr_addr_t CSR_PGDL    = 14'h019;
    localparam csr_addr_t CSR_PGDH    = 14'h01a;
    localparam csr_addr_t CSR_PGD     = 14'h01b;
    localparam csr_addr_t CSR_SAVE0   = 14'h030;
    localparam csr_addr_t CSR_SAVE1   = 14'h031;
    localparam csr_addr_t CSR_SAVE2   = 14'h032;
    localparam csr_addr_t CSR_SAVE3   = 14'h033;

    // Exception codes
    localparam logic [5:0] ECODE_INT  = 6'h00;
    localparam logic [5:0] ECODE_PIL  = 6'h01;
    localparam logic [5:0] ECODE_PIS  = 6'h02;
    localparam logic [5:0] ECODE_PIF  = 6'h03;
    localparam logic [5:0] ECODE_ADE  = 6'h08;
    localparam logic [5:0] ECODE_ALE  = 6'h09;
    localparam logic [5:0] ECODE_SYS  = 6'h0b;
    localparam logic [5:0] ECODE_BRK  = 6'h0c;
    localparam logic [5:0] ECODE_INE  = 6'h0d;
    localparam logic [5:0] ECODE_TLBR = 6'h3f;

    // Strongly-ordered uncached access type
    localparam logic [1:0] MAT_SUC = 2'b01;
    // da set, datf and datm at MAT_SUC
    localparam u32_t CRMD_RESET = 32'h0000_00a8;

    // Bits an instruction may write, per register
    localparam u32_t WM_CRMD   = 32'h0000_01ff;
    localparam u32_t WM_PRMD   = 32'h0000_0007;
    localparam u32_t WM_ESTAT  = 32'h0000_0003;
    localparam u32_t WM_EENTRY = 32'hffff_ffc0;
    localparam u32_t WM_TLBIDX = 32'hbf00_0000;
    localparam u32_t WM_TLBEHI = 32'hffff_e000;
    localparam u32_t WM_TLBELO = 32'h0fff_ff7f;
    localparam u32_t WM_ASID   = 32'h0000_03ff;
    localparam u32_t WM_PGD    = 32'hffff_f000;

    typedef struct packed {
        logic [22:0] r0;
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

    typedef struct packed {
        logic [28:0] r0;
        logic        pie;
        logic [1:0]  pplv;
    } prmd_t;

    typedef struct packed {
        logic        r0_hi;
        logic [8:0]  esubcode;
        logic [5:0]  ecode;
        logic [2:0]  r0_lo;
        logic [12:0] is;
    } estat_t;

    typedef struct packed {
        logic        ne;
        logic        r0_hi;
        logic [5:0]  ps;
        logic [7:0]  r0_lo;
        logic [15:0] index;
    } tlbidx_t;

    typedef struct packed {
        logic [18:0] vppn;
        logic [12:0] r0;
    } tlbehi_t;

    typedef struct packed {
        logic [3:0]  r0_hi;
        logic [19:0] ppn;
        logic        r0_lo;
        logic        g;
        logic [1:0]  mat;
        logic [1:0]  plv;
        logic        d;
        logic        v;
    } tlbelo_t;

    typedef struct packed {
        logic [7:0] r0_hi;
        logic [7:0] asidbits;
        logic [5:0] r0_lo;
        logic [9:0] asid;
    } asid_t;

    // Whole register image as seen by the other blocks
    typedef struct packed {
        crmd_t      crmd;
        prmd_t      prmd;
        estat_t     estat;
        u32_t       era;
        u32_t       badv;
        u32_t       eentry;
        tlbidx_t    tlbidx;
        tlbehi_t    tlbehi;
        tlbelo_t    tlbelo0;
        tlbelo_t    tlbelo1;
        asid_t      asid;
        u32_t       pgdl;
        u32_t       pgdh;
        u32_t       pgd;
        u32_t [3:0] save;
    } csr_t;

    typedef struct packed {
        logic   we;
        crmd_t  crmd;
        prmd_t  prmd;
        estat_t estat;
        u32_t   era;
        u32_t   badv;
    } excp_wr_req_t;

    typedef struct packed {
        logic    we;
        tlbidx_t tlbidx;
        tlbehi_t tlbehi;
        tlbelo_t tlbelo0;
        tlbelo_t tlbelo1;
        asid_t   asid;
    } tlb_wr_req_t;

    typedef struct packed {
        logic       valid;
        logic       ertn;
        logic [5:0] ecode;
        logic [8:0] esubcode;
        u32_t       pc;
        u32_t       badv;
    } excp_req_t;

    typedef struct packed {
        logic valid;
        u32_t pc;
    } redirect_t;

    typedef struct packed {
        logic srch;
        logic rd;
        logic wr;
    } tlb_op_t;

endpackage

`default_nettype wire
